// ==== logic/rv32i_alu.sv ====
// integer unit, register-register, register-immediate, LUI and AUIPC
// result and its write strobe are registered, one cycle after alu_en
`default_nettype none

module rv32i_alu (
    input  logic                          aclk,
    input  logic                          reset,
    input  logic                          alu_en,
    input  logic [2:0]                    funct3,
    input  logic                          funct7_5,
    input  logic [rv32i_pkg::regw-1:0]    rs1,
    input  logic [rv32i_pkg::regw-1:0]    rs2,
    input  logic [rv32i_pkg::regw-1:0]    rd,
    input  logic [rv32i_pkg::xlen-1:0]    imm,
    input  logic [rv32i_pkg::addrw-1:0]   pc,
    input  logic                          is_lui,
    input  logic                          is_auipc,
    input  logic                          is_imm,
    output logic [rv32i_pkg::regw-1:0]    rs1_addr,
    input  logic [rv32i_pkg::xlen-1:0]    rs1_val,
    output logic [rv32i_pkg::regw-1:0]    rs2_addr,
    input  logic [rv32i_pkg::xlen-1:0]    rs2_val,
    output logic                          rd_wr,
    output logic [rv32i_pkg::regw-1:0]    rd_addr,
    output logic [rv32i_pkg::xlen-1:0]    rd_val
);

    logic [rv32i_pkg::xlen-1:0]   op2;
    logic [rv32i_pkg::shamtw-1:0] shamt;
    logic [rv32i_pkg::xlen-1:0]   pc_ext;
    logic [rv32i_pkg::xlen-1:0]   result;

    assign rs1_addr = rs1;
    assign rs2_addr = rs2;

    assign op2    = is_imm ? imm : rs2_val;
    assign shamt  = op2[rv32i_pkg::shamtw-1:0];
    assign pc_ext = {{(rv32i_pkg::xlen - rv32i_pkg::addrw){1'b0}}, pc};

    always_comb begin
        case (funct3)
            // bit 30 selects sub only for register-register
            rv32i_pkg::f3_add:  result = (funct7_5 && !is_imm) ? rs1_val - op2
                                                               : rs1_val + op2;
            rv32i_pkg::f3_sll:  result = rs1_val << shamt;
            rv32i_pkg::f3_slt:  result = {{(rv32i_pkg::xlen-1){1'b0}},
                                          $signed(rs1_val) < $signed(op2)};
            rv32i_pkg::f3_sltu: result = {{(rv32i_pkg::xlen-1){1'b0}}, rs1_val < op2};
            rv32i_pkg::f3_xor:  result = rs1_val ^ op2;
            // bit 30 picks arithmetic shift for both srai and sra
            rv32i_pkg::f3_sr:   result = funct7_5 ? $unsigned($signed(rs1_val) >>> shamt)
                                                  : rs1_val >> shamt;
            rv32i_pkg::f3_or:   result = rs1_val | op2;
            default:            result = rs1_val & op2;
        endcase
        // U-type words carry immediate bits in the funct3 position
        if (is_lui) begin
            result = imm;
        end else if (is_auipc) begin
            result = pc_ext + imm;
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            rd_wr <= 1'b0;
        end else begin
            rd_wr <= alu_en;
        end
    end

    always_ff @(posedge aclk) begin
        if (alu_en) begin
            rd_addr <= rd;
            rd_val  <= result;
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv32i_decoder.sv ====
// combinational instruction decoder of the execution stage
// splits the word into fields and immediates and steers it to the ALU or memfy
`default_nettype none

module rv32i_decoder (
    input  logic                          proc_en,
    input  rv32i_pkg::instr_t             proc_instr,
    input  logic [rv32i_pkg::addrw-1:0]   proc_pc,
    output logic                          alu_en,
    output logic                          memfy_en,
    output logic [2:0]                    funct3,
    output logic                          funct7_5,
    output logic [rv32i_pkg::regw-1:0]    rs1,
    output logic [rv32i_pkg::regw-1:0]    rs2,
    output logic [rv32i_pkg::regw-1:0]    rd,
    output logic [rv32i_pkg::xlen-1:0]    imm,
    output logic [rv32i_pkg::addrw-1:0]   pc,
    output logic                          is_lui,
    output logic                          is_auipc,
    output logic                          is_imm,
    output logic                          is_store,
    output logic                          is_fence
);

    logic [6:0] opcode;
    logic       is_op;
    logic       is_load;

    assign opcode = proc_instr.r_fmt.opcode;

    // opcode classes
    assign is_lui   = (opcode == rv32i_pkg::op_lui);
    assign is_auipc = (opcode == rv32i_pkg::op_auipc);
    assign is_imm   = (opcode == rv32i_pkg::op_opimm);
    assign is_op    = (opcode == rv32i_pkg::op_op);
    assign is_load  = (opcode == rv32i_pkg::op_load);
    assign is_store = (opcode == rv32i_pkg::op_store);
    assign is_fence = (opcode == rv32i_pkg::op_fence);

    // unknown opcodes raise neither strobe
    assign alu_en   = proc_en & (is_lui | is_auipc | is_imm | is_op);
    assign memfy_en = proc_en & (is_load | is_store | is_fence);

    // fields sit at the same place in every format that has them
    assign funct3   = proc_instr.r_fmt.funct3;
    assign funct7_5 = proc_instr.r_fmt.funct7[5];
    assign rs1      = proc_instr.i_fmt.rs1;
    assign rs2      = proc_instr.s_fmt.rs2;
    assign rd       = proc_instr.u_fmt.rd;
    assign pc       = proc_pc;

    always_comb begin
        if (is_lui || is_auipc) begin
            // U-type, upper 20 bits
            imm = {proc_instr.u_fmt.imm, 12'b0};
        end else if (is_store) begin
            imm = {{20{proc_instr.s_fmt.imm_hi[6]}},
                   proc_instr.s_fmt.imm_hi,
                   proc_instr.s_fmt.imm_lo};
        end else begin
            // I-type for op-imm, loads and fence
            imm = {{20{proc_instr.i_fmt.imm[11]}}, proc_instr.i_fmt.imm};
        end
    end

endmodule

`default_nettype wire

// ==== logic/rv32i_memfy.sv ====
// load/store unit, drives the data memory port and writes loaded values back
// one access at a time, request held until mem_ready, fence only pulses fenceinfo
`default_nettype none

module rv32i_memfy (
    input  logic                          aclk,
    input  logic                          reset,
    input  logic                          memfy_en,
    output logic                          memfy_ready,
    output logic                          memfy_empty,
    output logic [3:0]                    fenceinfo,
    input  logic [2:0]                    funct3,
    input  logic [rv32i_pkg::regw-1:0]    rs1,
    input  logic [rv32i_pkg::regw-1:0]    rs2,
    input  logic [rv32i_pkg::regw-1:0]    rd,
    input  logic [rv32i_pkg::xlen-1:0]    imm,
    input  logic                          is_store,
    input  logic                          is_fence,
    output logic [rv32i_pkg::regw-1:0]    rs1_addr,
    input  logic [rv32i_pkg::xlen-1:0]    rs1_val,
    output logic [rv32i_pkg::regw-1:0]    rs2_addr,
    input  logic [rv32i_pkg::xlen-1:0]    rs2_val,
    output logic                          rd_wr,
    output logic [rv32i_pkg::regw-1:0]    rd_addr,
    output logic [rv32i_pkg::xlen-1:0]    rd_val,
    output logic                          mem_en,
    output logic                          mem_wr,
    output logic [rv32i_pkg::addrw-1:0]   mem_addr,
    output logic [rv32i_pkg::xlen-1:0]    mem_wdata,
    output logic [rv32i_pkg::strbw-1:0]   mem_strb,
    input  logic [rv32i_pkg::xlen-1:0]    mem_rdata,
    input  logic                          mem_ready
);

    // high from acceptance until the memory answers
    logic                          busy;
    logic                          accept;
    logic [2:0]                    ld_funct3;
    logic [rv32i_pkg::xlen-1:0]    addr_full;
    logic [1:0]                    lane;
    logic [rv32i_pkg::xlen-1:0]    wdata_lane;
    logic [rv32i_pkg::strbw-1:0]   strb_lane;
    logic [rv32i_pkg::xlen-1:0]    rdata_shift;
    logic [rv32i_pkg::xlen-1:0]    load_val;

    assign rs1_addr = rs1;
    assign rs2_addr = rs2;

    assign accept    = memfy_en & ~busy;
    assign addr_full = rs1_val + imm;
    assign lane      = addr_full[1:0];

    // store data and strobes moved to the byte lane of the address
    always_comb begin
        case (funct3)
            rv32i_pkg::f3_b: begin
                wdata_lane = {{(rv32i_pkg::xlen-8){1'b0}}, rs2_val[7:0]} << {lane, 3'b000};
                strb_lane  = {{(rv32i_pkg::strbw-1){1'b0}}, 1'b1} << lane;
            end
            rv32i_pkg::f3_h: begin
                wdata_lane = {{(rv32i_pkg::xlen-16){1'b0}}, rs2_val[15:0]} << {lane, 3'b000};
                strb_lane  = {{(rv32i_pkg::strbw-2){1'b0}}, 2'b11} << lane;
            end
            default: begin
                wdata_lane = rs2_val;
                strb_lane  = '1;
            end
        endcase
    end

    // load data taken from its lane, then sign or zero extended
    assign rdata_shift = mem_rdata >> {mem_addr[1:0], 3'b000};

    always_comb begin
        case (ld_funct3)
            rv32i_pkg::f3_b:  load_val = {{24{rdata_shift[7]}}, rdata_shift[7:0]};
            rv32i_pkg::f3_bu: load_val = {24'b0, rdata_shift[7:0]};
            rv32i_pkg::f3_h:  load_val = {{16{rdata_shift[15]}}, rdata_shift[15:0]};
            rv32i_pkg::f3_hu: load_val = {16'b0, rdata_shift[15:0]};
            default:          load_val = rdata_shift;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            busy      <= 1'b0;
            mem_en    <= 1'b0;
            rd_wr     <= 1'b0;
            fenceinfo <= '0;
        end else begin
            rd_wr     <= 1'b0;
            fenceinfo <= '0;
            if (accept && is_fence) begin
                // pred bits of the fence, no memory traffic
                fenceinfo <= imm[7:4];
            end else if (accept) begin
                busy   <= 1'b1;
                mem_en <= 1'b1;
            end else if (busy && mem_ready) begin
                busy   <= 1'b0;
                mem_en <= 1'b0;
                rd_wr  <= ~mem_wr;
            end
        end
    end

    // request payload, stable while mem_en waits for mem_ready
    always_ff @(posedge aclk) begin
        if (accept) begin
            mem_wr    <= is_store;
            mem_addr  <= addr_full[rv32i_pkg::addrw-1:0];
            mem_wdata <= wdata_lane;
            mem_strb  <= is_store ? strb_lane : '1;
            ld_funct3 <= funct3;
            rd_addr   <= rd;
        end
        if (busy && mem_ready) begin
            rd_val <= load_val;
        end
    end

    // ready returns once a loaded value has reached the register file
    assign memfy_ready = ~busy & ~rd_wr;
    assign memfy_empty = ~busy;

endmodule

`default_nettype wire

// ==== logic/rv32i_pkg.sv ====
// widths, RV32I opcode and funct3 encodings, and the instruction word views
// every execution stage module refers to these by scoped name
`default_nettype none

package rv32i_pkg;

    localparam int xlen   = 32;
    localparam int addrw  = 16;
    localparam int regw   = 5;
    localparam int strbw  = xlen / 8;
    localparam int shamtw = $clog2(xlen);

    // major opcodes handled by the stage
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_auipc = 7'b0010111;
    localparam logic [6:0] op_opimm = 7'b0010011;
    localparam logic [6:0] op_op    = 7'b0110011;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;
    localparam logic [6:0] op_fence = 7'b0001111;

    // integer funct3
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    // load/store funct3, width and signedness
    localparam logic [2:0] f3_b  = 3'b000;
    localparam logic [2:0] f3_h  = 3'b001;
    localparam logic [2:0] f3_w  = 3'b010;
    localparam logic [2:0] f3_bu = 3'b100;
    localparam logic [2:0] f3_hu = 3'b101;

    // one instruction word seen through each base format
    typedef union packed {
        struct packed {
            logic [6:0]      funct7;
            logic [regw-1:0] rs2;
            logic [regw-1:0] rs1;
            logic [2:0]      funct3;
            logic [regw-1:0] rd;
            logic [6:0]      opcode;
        } r_fmt;
        struct packed {
            logic [11:0]     imm;
            logic [regw-1:0] rs1;
            logic [2:0]      funct3;
            logic [regw-1:0] rd;
            logic [6:0]      opcode;
        } i_fmt;
        struct packed {
            logic [6:0]      imm_hi;
            logic [regw-1:0] rs2;
            logic [regw-1:0] rs1;
            logic [2:0]      funct3;
            logic [4:0]      imm_lo;
            logic [6:0]      opcode;
        } s_fmt;
        struct packed {
            logic [19:0]     imm;
            logic [regw-1:0] rd;
            logic [6:0]      opcode;
        } u_fmt;
    } instr_t;

endpackage

`default_nettype wire

// ==== logic/rv32i_processing.sv ====
// RV32I execution stage top, decoder feeding the ALU and memfy over one register file
// the data memory port of memfy is brought straight out
`default_nettype none

module rv32i_processing (
    input  logic                          aclk,
    input  logic                          reset,
    input  logic                          proc_en,
    output logic                          proc_ready,
    output logic                          proc_empty,
    output logic [3:0]                    proc_fenceinfo,
    input  rv32i_pkg::instr_t             proc_instr,
    input  logic [rv32i_pkg::addrw-1:0]   proc_pc,
    output logic                          mem_en,
    output logic                          mem_wr,
    output logic [rv32i_pkg::addrw-1:0]   mem_addr,
    output logic [rv32i_pkg::xlen-1:0]    mem_wdata,
    output logic [rv32i_pkg::strbw-1:0]   mem_strb,
    input  logic [rv32i_pkg::xlen-1:0]    mem_rdata,
    input  logic                          mem_ready
);

    // decoded fields shared by both units
    logic                          alu_en;
    logic                          memfy_en;
    logic [2:0]                    funct3;
    logic                          funct7_5;
    logic [rv32i_pkg::regw-1:0]    rs1;
    logic [rv32i_pkg::regw-1:0]    rs2;
    logic [rv32i_pkg::regw-1:0]    rd;
    logic [rv32i_pkg::xlen-1:0]    imm;
    logic [rv32i_pkg::addrw-1:0]   pc;
    logic                          is_lui;
    logic                          is_auipc;
    logic                          is_imm;
    logic                          is_store;
    logic                          is_fence;

    // register file ports of each unit
    logic [rv32i_pkg::regw-1:0]    alu_rs1_addr;
    logic [rv32i_pkg::xlen-1:0]    alu_rs1_val;
    logic [rv32i_pkg::regw-1:0]    alu_rs2_addr;
    logic [rv32i_pkg::xlen-1:0]    alu_rs2_val;
    logic                          alu_rd_wr;
    logic [rv32i_pkg::regw-1:0]    alu_rd_addr;
    logic [rv32i_pkg::xlen-1:0]    alu_rd_val;
    logic [rv32i_pkg::regw-1:0]    memfy_rs1_addr;
    logic [rv32i_pkg::xlen-1:0]    memfy_rs1_val;
    logic [rv32i_pkg::regw-1:0]    memfy_rs2_addr;
    logic [rv32i_pkg::xlen-1:0]    memfy_rs2_val;
    logic                          memfy_rd_wr;
    logic [rv32i_pkg::regw-1:0]    memfy_rd_addr;
    logic [rv32i_pkg::xlen-1:0]    memfy_rd_val;
    logic                          memfy_ready;
    logic                          memfy_empty;

    rv32i_decoder decoder (
        .proc_en, .proc_instr, .proc_pc,
        .alu_en, .memfy_en,
        .funct3, .funct7_5,
        .rs1, .rs2, .rd,
        .imm, .pc,
        .is_lui, .is_auipc, .is_imm,
        .is_store, .is_fence
    );

    rv32i_alu alu (
        .aclk, .reset,
        .alu_en,
        .funct3, .funct7_5,
        .rs1, .rs2, .rd,
        .imm, .pc,
        .is_lui, .is_auipc, .is_imm,
        .rs1_addr (alu_rs1_addr),
        .rs1_val  (alu_rs1_val),
        .rs2_addr (alu_rs2_addr),
        .rs2_val  (alu_rs2_val),
        .rd_wr    (alu_rd_wr),
        .rd_addr  (alu_rd_addr),
        .rd_val   (alu_rd_val)
    );

    rv32i_memfy memfy (
        .aclk, .reset,
        .memfy_en, .memfy_ready, .memfy_empty,
        .fenceinfo (proc_fenceinfo),
        .funct3,
        .rs1, .rs2, .rd,
        .imm, .is_store, .is_fence,
        .rs1_addr  (memfy_rs1_addr),
        .rs1_val   (memfy_rs1_val),
        .rs2_addr  (memfy_rs2_addr),
        .rs2_val   (memfy_rs2_val),
        .rd_wr     (memfy_rd_wr),
        .rd_addr   (memfy_rd_addr),
        .rd_val    (memfy_rd_val),
        .mem_en, .mem_wr, .mem_addr,
        .mem_wdata, .mem_strb,
        .mem_rdata, .mem_ready
    );

    rv32i_regfile regfile (
        .aclk, .reset,
        .alu_rs1_addr, .alu_rs1_val,
        .alu_rs2_addr, .alu_rs2_val,
        .memfy_rs1_addr, .memfy_rs1_val,
        .memfy_rs2_addr, .memfy_rs2_val,
        .alu_rd_wr, .alu_rd_addr, .alu_rd_val,
        .memfy_rd_wr, .memfy_rd_addr, .memfy_rd_val
    );

    // the ALU is always ready, but its result must land before the next issue
    assign proc_ready = memfy_ready & ~alu_rd_wr;
    assign proc_empty = memfy_empty & ~alu_rd_wr;

endmodule

`default_nettype wire

// ==== logic/rv32i_regfile.sv ====
// shared integer register file where x0 reads as zero and ignores writes
// four combinational read ports and two write ports with memfy winning a collision
`default_nettype none

module rv32i_regfile (
    input  logic                          aclk,
    input  logic                          reset,
    input  logic [rv32i_pkg::regw-1:0]    alu_rs1_addr,
    output logic [rv32i_pkg::xlen-1:0]    alu_rs1_val,
    input  logic [rv32i_pkg::regw-1:0]    alu_rs2_addr,
    output logic [rv32i_pkg::xlen-1:0]    alu_rs2_val,
    input  logic [rv32i_pkg::regw-1:0]    memfy_rs1_addr,
    output logic [rv32i_pkg::xlen-1:0]    memfy_rs1_val,
    input  logic [rv32i_pkg::regw-1:0]    memfy_rs2_addr,
    output logic [rv32i_pkg::xlen-1:0]    memfy_rs2_val,
    input  logic                          alu_rd_wr,
    input  logic [rv32i_pkg::regw-1:0]    alu_rd_addr,
    input  logic [rv32i_pkg::xlen-1:0]    alu_rd_val,
    input  logic                          memfy_rd_wr,
    input  logic [rv32i_pkg::regw-1:0]    memfy_rd_addr,
    input  logic [rv32i_pkg::xlen-1:0]    memfy_rd_val
);

    logic [rv32i_pkg::xlen-1:0] regs [1:31];

    // no bypass since a unit issues only after earlier writes have landed
    assign alu_rs1_val   = (alu_rs1_addr == '0) ? '0 : regs[alu_rs1_addr];
    assign alu_rs2_val   = (alu_rs2_addr == '0) ? '0 : regs[alu_rs2_addr];
    assign memfy_rs1_val = (memfy_rs1_addr == '0) ? '0 : regs[memfy_rs1_addr];
    assign memfy_rs2_val = (memfy_rs2_addr == '0) ? '0 : regs[memfy_rs2_addr];

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (alu_rd_wr && alu_rd_addr != '0) begin
                regs[alu_rd_addr] <= alu_rd_val;
            end
            // the later assignment lets memfy take the slot on a clash
            if (memfy_rd_wr && memfy_rd_addr != '0) begin
                regs[memfy_rd_addr] <= memfy_rd_val;
            end
        end
    end

endmodule

`default_nettype wire

// ==== rv32i_processing.f ====
logic/rv32i_pkg.sv
logic/rv32i_decoder.sv
logic/rv32i_alu.sv
logic/rv32i_memfy.sv
logic/rv32i_regfile.sv
logic/rv32i_processing.sv
testbench/rv32i_dmem_model.sv
testbench/rv32i_processing_tb.sv

// ==== testbench/rv32i_dmem_model.sv ====
// byte-addressed data memory for the execution stage testbench, little-endian words
// every request waits 0 to 3 random cycles before mem_ready answers
`default_nettype none

module rv32i_dmem_model #(
    parameter logic [31:0] seed = 32'h0000_0001
) (
    input  logic                          aclk,
    input  logic                          reset,
    input  logic                          mem_en,
    input  logic                          mem_wr,
    input  logic [rv32i_pkg::addrw-1:0]   mem_addr,
    input  logic [rv32i_pkg::xlen-1:0]    mem_wdata,
    input  logic [rv32i_pkg::strbw-1:0]   mem_strb,
    output logic [rv32i_pkg::xlen-1:0]    mem_rdata,
    output logic                          mem_ready
);

    logic [7:0]                  mem_bytes [0:(1 << rv32i_pkg::addrw) - 1];
    logic [rv32i_pkg::addrw-1:0] base;
    // set once a wait count has been drawn for the current request
    logic                        counting;
    logic [1:0]                  wait_left;

    assign base      = {mem_addr[rv32i_pkg::addrw-1:2], 2'b00};
    assign mem_rdata = {mem_bytes[base + 3], mem_bytes[base + 2],
                        mem_bytes[base + 1], mem_bytes[base]};
    assign mem_ready = mem_en & counting & (wait_left == 2'd0);

    initial begin
        void'($urandom(seed));
        for (int a = 0; a < (1 << rv32i_pkg::addrw); a++) begin
            mem_bytes[a] = a[7:0] ^ a[15:8] ^ 8'h5a;
        end
        counting  = 1'b0;
        wait_left = 2'd0;
        forever begin
            @(posedge aclk);
            if (reset) begin
                counting <= 1'b0;
            end else if (mem_en && !counting) begin
                counting  <= 1'b1;
                wait_left <= 2'($urandom_range(3, 0));
            end else if (mem_en && wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else if (mem_en) begin
                // the access completes at this edge
                counting <= 1'b0;
                if (mem_wr) begin
                    for (int l = 0; l < rv32i_pkg::strbw; l++) begin
                        if (mem_strb[l]) begin
                            mem_bytes[base + l] <= mem_wdata[8*l +: 8];
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== testbench/rv32i_processing_tb.sv ====
// testbench for the RV32I execution stage
// runs an instruction table through the DUT and checks the stores that register results cause
`default_nettype none

module rv32i_processing_tb;

    localparam int          clk_period = 20;
    localparam logic [31:0] rand_seed  = 32'hada6_6977;
    localparam logic [15:0] pc_value   = 16'h0a40;

    logic                          aclk;
    logic                          reset;
    logic                          proc_en;
    logic                          proc_ready;
    logic                          proc_empty;
    logic [3:0]                    proc_fenceinfo;
    rv32i_pkg::instr_t             proc_instr;
    logic [rv32i_pkg::addrw-1:0]   proc_pc;
    logic                          mem_en;
    logic                          mem_wr;
    logic [rv32i_pkg::addrw-1:0]   mem_addr;
    logic [rv32i_pkg::xlen-1:0]    mem_wdata;
    logic [rv32i_pkg::strbw-1:0]   mem_strb;
    logic [rv32i_pkg::xlen-1:0]    mem_rdata;
    logic                          mem_ready;

    // one table row per instruction with its expected store and fence info
    rv32i_pkg::instr_t word_q [$];
    logic              store_q [$];
    logic [15:0]       addr_q [$];
    logic [31:0]       data_q [$];
    logic [3:0]        strb_q [$];
    logic [3:0]        fence_q [$];
    logic              table_built;

    rv32i_processing uut (
        .aclk, .reset,
        .proc_en, .proc_ready, .proc_empty, .proc_fenceinfo,
        .proc_instr, .proc_pc,
        .mem_en, .mem_wr, .mem_addr, .mem_wdata, .mem_strb,
        .mem_rdata, .mem_ready
    );

    rv32i_dmem_model #(.seed(rand_seed)) dmem (
        .aclk, .reset,
        .mem_en, .mem_wr, .mem_addr, .mem_wdata, .mem_strb,
        .mem_rdata, .mem_ready
    );

    initial begin
        aclk = 1'b0;
        forever #(clk_period / 2) aclk = ~aclk;
    end

    function automatic rv32i_pkg::instr_t r_word(input logic [6:0] funct7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] funct3,
                                                 input logic [4:0] rd);
        rv32i_pkg::instr_t w;
        w.r_fmt = {funct7, rs2, rs1, funct3, rd, rv32i_pkg::op_op};
        return w;
    endfunction

    function automatic rv32i_pkg::instr_t i_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] funct3, input logic [4:0] rd,
                                                 input logic [6:0] opcode);
        rv32i_pkg::instr_t w;
        w.i_fmt = {imm, rs1, funct3, rd, opcode};
        return w;
    endfunction

    function automatic rv32i_pkg::instr_t s_word(input logic [11:0] imm, input logic [4:0] rs2,
                                                 input logic [2:0] funct3);
        rv32i_pkg::instr_t w;
        // base register is always x0 and the offset is the address
        w.s_fmt = {imm[11:5], rs2, 5'd0, funct3, imm[4:0], rv32i_pkg::op_store};
        return w;
    endfunction

    function automatic rv32i_pkg::instr_t u_word(input logic [19:0] imm, input logic [4:0] rd,
                                                 input logic [6:0] opcode);
        rv32i_pkg::instr_t w;
        w.u_fmt = {imm, rd, opcode};
        return w;
    endfunction

    task automatic add_step(input rv32i_pkg::instr_t word, input logic store,
                            input logic [15:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input logic [3:0] fence);
        word_q.push_back(word);
        store_q.push_back(store);
        addr_q.push_back(addr);
        data_q.push_back(data);
        strb_q.push_back(strb);
        fence_q.push_back(fence);
    endtask

    task automatic run_op(input rv32i_pkg::instr_t word);
        add_step(word, 1'b0, 16'h0, 32'h0, 4'h0, 4'h0);
    endtask

    task automatic expect_store(input logic [2:0] funct3, input logic [4:0] rs2,
                                input logic [15:0] addr, input logic [31:0] data,
                                input logic [3:0] strb);
        add_step(s_word(addr[11:0], rs2, funct3), 1'b1, addr, data, strb, 4'h0);
    endtask

    task automatic expect_word(input logic [4:0] rs2, input logic [15:0] addr,
                               input logic [31:0] data);
        expect_store(rv32i_pkg::f3_w, rs2, addr, data, 4'hf);
    endtask

    task automatic build_table();
        // ADDI, LUI and AUIPC followed by a store of each register
        run_op(i_word(12'h123, 5'd0, rv32i_pkg::f3_add, 5'd1, rv32i_pkg::op_opimm));
        run_op(i_word(12'hffb, 5'd0, rv32i_pkg::f3_add, 5'd2, rv32i_pkg::op_opimm));
        run_op(u_word(20'habcde, 5'd3, rv32i_pkg::op_lui));
        run_op(u_word(20'h00012, 5'd4, rv32i_pkg::op_auipc));
        run_op(i_word(12'h004, 5'd0, rv32i_pkg::f3_add, 5'd8, rv32i_pkg::op_opimm));
        expect_word(5'd1, 16'h0100, 32'h0000_0123);
        expect_word(5'd2, 16'h0104, 32'hffff_fffb);
        expect_word(5'd3, 16'h0108, 32'habcd_e000);
        expect_word(5'd4, 16'h010c, 32'h0001_2a40);
        expect_word(5'd8, 16'h0110, 32'h0000_0004);
        // register-register operations
        run_op(r_word(7'h00, 5'd2, 5'd1, rv32i_pkg::f3_add, 5'd5));
        run_op(r_word(7'h20, 5'd2, 5'd1, rv32i_pkg::f3_add, 5'd6));
        run_op(r_word(7'h00, 5'd8, 5'd1, rv32i_pkg::f3_sll, 5'd7));
        run_op(r_word(7'h00, 5'd8, 5'd3, rv32i_pkg::f3_sr, 5'd9));
        run_op(r_word(7'h20, 5'd8, 5'd3, rv32i_pkg::f3_sr, 5'd10));
        run_op(r_word(7'h00, 5'd2, 5'd1, rv32i_pkg::f3_slt, 5'd11));
        run_op(r_word(7'h00, 5'd2, 5'd1, rv32i_pkg::f3_sltu, 5'd12));
        run_op(r_word(7'h00, 5'd3, 5'd1, rv32i_pkg::f3_xor, 5'd13));
        run_op(r_word(7'h00, 5'd4, 5'd1, rv32i_pkg::f3_or, 5'd14));
        run_op(r_word(7'h00, 5'd4, 5'd13, rv32i_pkg::f3_and, 5'd15));
        expect_word(5'd5, 16'h0114, 32'h0000_011e);
        expect_word(5'd6, 16'h0118, 32'h0000_0128);
        expect_word(5'd7, 16'h011c, 32'h0000_1230);
        expect_word(5'd9, 16'h0120, 32'h0abc_de00);
        expect_word(5'd10, 16'h0124, 32'hfabc_de00);
        expect_word(5'd11, 16'h0128, 32'h0000_0000);
        expect_word(5'd12, 16'h012c, 32'h0000_0001);
        expect_word(5'd13, 16'h0130, 32'habcd_e123);
        expect_word(5'd14, 16'h0134, 32'h0001_2b63);
        expect_word(5'd15, 16'h0138, 32'h0001_2000);
        // byte and halfword stores at each lane
        expect_store(rv32i_pkg::f3_b, 5'd13, 16'h0200, 32'h0000_0023, 4'h1);
        expect_store(rv32i_pkg::f3_b, 5'd13, 16'h0201, 32'h0000_2300, 4'h2);
        expect_store(rv32i_pkg::f3_b, 5'd13, 16'h0202, 32'h0023_0000, 4'h4);
        expect_store(rv32i_pkg::f3_b, 5'd13, 16'h0203, 32'h2300_0000, 4'h8);
        expect_store(rv32i_pkg::f3_h, 5'd13, 16'h0204, 32'h0000_e123, 4'h3);
        expect_store(rv32i_pkg::f3_h, 5'd13, 16'h0206, 32'he123_0000, 4'hc);
        // loads from the words written above with each result stored back out
        run_op(i_word(12'h10b, 5'd0, rv32i_pkg::f3_b, 5'd16, rv32i_pkg::op_load));
        run_op(i_word(12'h10b, 5'd0, rv32i_pkg::f3_bu, 5'd17, rv32i_pkg::op_load));
        run_op(i_word(12'h10a, 5'd0, rv32i_pkg::f3_h, 5'd18, rv32i_pkg::op_load));
        run_op(i_word(12'h10a, 5'd0, rv32i_pkg::f3_hu, 5'd19, rv32i_pkg::op_load));
        run_op(i_word(12'h104, 5'd0, rv32i_pkg::f3_w, 5'd20, rv32i_pkg::op_load));
        run_op(i_word(12'h201, 5'd0, rv32i_pkg::f3_b, 5'd21, rv32i_pkg::op_load));
        run_op(i_word(12'h206, 5'd0, rv32i_pkg::f3_h, 5'd22, rv32i_pkg::op_load));
        run_op(i_word(12'h204, 5'd0, rv32i_pkg::f3_hu, 5'd23, rv32i_pkg::op_load));
        expect_word(5'd16, 16'h0300, 32'hffff_ffab);
        expect_word(5'd17, 16'h0304, 32'h0000_00ab);
        expect_word(5'd18, 16'h0308, 32'hffff_abcd);
        expect_word(5'd19, 16'h030c, 32'h0000_abcd);
        expect_word(5'd20, 16'h0310, 32'hffff_fffb);
        expect_word(5'd21, 16'h0314, 32'h0000_0023);
        expect_word(5'd22, 16'h0318, 32'hffff_e123);
        expect_word(5'd23, 16'h031c, 32'h0000_e123);
        // fence pred bits and writes to x0 that must not stick
        add_step(i_word(12'h0a5, 5'd0, 3'b000, 5'd0, rv32i_pkg::op_fence), 1'b0, 16'h0, 32'h0,
                 4'h0, 4'ha);
        add_step(i_word(12'h03f, 5'd0, 3'b000, 5'd0, rv32i_pkg::op_fence), 1'b0, 16'h0, 32'h0,
                 4'h0, 4'h3);
        run_op(i_word(12'h7ff, 5'd0, rv32i_pkg::f3_add, 5'd0, rv32i_pkg::op_opimm));
        run_op(r_word(7'h00, 5'd1, 5'd3, rv32i_pkg::f3_add, 5'd0));
        expect_word(5'd0, 16'h0400, 32'h0000_0000);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s got %h expected %h", name, got, exp);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic wait_ready();
        while (proc_ready !== 1'b1) begin
            @(negedge aclk);
        end
    endtask

    task automatic run_table();
        logic store_done;
        for (int i = 0; i < word_q.size(); i++) begin
            wait_ready();
            proc_en    = 1'b1;
            proc_instr = word_q[i];
            @(negedge aclk);
            proc_en = 1'b0;
            check_value("proc_fenceinfo", proc_fenceinfo, fence_q[i]);
            if (fence_q[i] != 4'h0) begin
                check_value("mem_en", mem_en, 1'b0);
            end
            store_done = 1'b0;
            // memfy holds the request until the memory answers
            while (mem_en) begin
                check_value("proc_ready", proc_ready, 1'b0);
                check_value("proc_empty", proc_empty, 1'b0);
                if (mem_ready && mem_wr) begin
                    store_done = 1'b1;
                    check_value("mem_addr", mem_addr, addr_q[i]);
                    check_value("mem_wdata", mem_wdata, data_q[i]);
                    check_value("mem_strb", mem_strb, strb_q[i]);
                end
                @(negedge aclk);
            end
            check_value("store_done", store_done, store_q[i]);
        end
    endtask

    initial begin
        reset       = 1'b1;
        proc_en     = 1'b0;
        proc_instr  = '0;
        proc_pc     = pc_value;
        table_built = 1'b0;
        build_table();
        table_built = 1'b1;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
        // idle state straight after reset
        check_value("mem_en", mem_en, 1'b0);
        check_value("proc_ready", proc_ready, 1'b1);
        check_value("proc_empty", proc_empty, 1'b1);
        check_value("proc_fenceinfo", proc_fenceinfo, 4'h0);
        run_table();
        wait_ready();
        check_value("proc_empty", proc_empty, 1'b1);
        $display("All tests passed");
        $finish;
    end

    // generous bound of 20 cycles for each table row
    initial begin
        wait (table_built === 1'b1);
        #((word_q.size() * 20 + 10) * clk_period);
        $display("timeout before the instruction table completed");
        $display("Some tests failed");
        $fatal(1);
    end

endmodule

`default_nettype wire
